// ==== source/vsldu_pkg.sv ====
// Vector slide unit definitions
package vsldu_pkg;

    // widest supported element, also the scalar operand width
    localparam int ELEN = 32;
    localparam int ELEN_BYTES = ELEN / 8;
    localparam int EB_W = $clog2(ELEN_BYTES + 1);  // holds 1 up to ELEN_BYTES

    localparam int MAX_LMUL = 4;  // largest register group

    // slide unit operations
    typedef enum logic [2:0] {
        SLDU_SLIDEUP    = 3'd0,  // offset taken from scalar
        SLDU_SLIDEDOWN  = 3'd1,  // offset taken from scalar
        SLDU_SLIDE1UP   = 3'd2,  // scalar enters at element 0
        SLDU_SLIDE1DOWN = 3'd3,  // scalar enters at top element
        SLDU_VMV        = 3'd4   // scalar to element 0, rest cleared
    } sldu_op_e;

    // element width, vsew encoding
    typedef enum logic [2:0] {
        SEW_8  = 3'b000,
        SEW_16 = 3'b001,
        SEW_32 = 3'b010
    } sew_e;

    // register group size, vlmul encoding
    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010
    } lmul_e;

    // reserved sew and lmul codes fall back to 8 bits and 1 register

endpackage

// ==== source/vsldu_decode.sv ====
// Vector slide decode stage
`timescale 1ns/100ps

module vsldu_decode #(
    parameter int VLEN = 128
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           in_valid,
    output logic                                           in_ready,
    input  vsldu_pkg::sldu_op_e                            op,
    input  vsldu_pkg::sew_e                                sew,
    input  vsldu_pkg::lmul_e                               lmul,
    input  logic [vsldu_pkg::MAX_LMUL*VLEN-1:0]            vs2,
    input  logic [vsldu_pkg::ELEN-1:0]                     scalar,
    output logic                                           dec_valid,
    input  logic                                           dec_ready,
    output logic                                           slide_down,
    output logic [$clog2(vsldu_pkg::MAX_LMUL*VLEN/8+1)-1:0] shift_bytes,
    output logic                                           keep_prefix,
    output logic                                           insert_low,
    output logic                                           insert_high,
    output logic [vsldu_pkg::EB_W-1:0]                     elem_bytes,
    output logic [$clog2(vsldu_pkg::MAX_LMUL*VLEN/8+1)-1:0] group_bytes,
    output logic [vsldu_pkg::MAX_LMUL*VLEN-1:0]            dec_vs2,
    output logic [vsldu_pkg::ELEN-1:0]                     dec_scalar
);
    import vsldu_pkg::*;

    localparam int DW        = MAX_LMUL * VLEN;
    localparam int REG_BYTES = VLEN / 8;
    localparam int GB_W      = $clog2(DW / 8 + 1);
    localparam int SH_W      = ELEN + EB_W;  // k times element bytes never overflows

    logic [EB_W-1:0] eb_d;
    logic [GB_W-1:0] gb_d;
    logic [GB_W-1:0] sh_d;
    logic [ELEN-1:0] k_elems;
    logic [SH_W-1:0] sh_full;
    logic            whole_group;
    logic            down_d;
    logic            keep_d;
    logic            ins_lo_d;
    logic            ins_hi_d;

    // element and group sizes in bytes
    always_comb begin
        case (sew)
            SEW_16:  eb_d = EB_W'(2);
            SEW_32:  eb_d = EB_W'(4);
            default: eb_d = EB_W'(1);
        endcase
        case (lmul)
            LMUL_2:  gb_d = GB_W'(2 * REG_BYTES);
            LMUL_4:  gb_d = GB_W'(4 * REG_BYTES);
            default: gb_d = GB_W'(REG_BYTES);
        endcase
    end

    // operation to slide controls
    always_comb begin
        down_d      = 1'b0;
        keep_d      = 1'b0;
        ins_lo_d    = 1'b0;
        ins_hi_d    = 1'b0;
        whole_group = 1'b0;
        k_elems     = scalar;
        case (op)
            SLDU_SLIDEUP: begin
                keep_d = 1'b1;  // low k elements stay as source
            end
            SLDU_SLIDEDOWN: begin
                down_d = 1'b1;
            end
            SLDU_SLIDE1UP: begin
                k_elems  = ELEN'(1);
                ins_lo_d = 1'b1;
            end
            SLDU_SLIDE1DOWN: begin
                down_d   = 1'b1;
                k_elems  = ELEN'(1);
                ins_hi_d = 1'b1;
            end
            SLDU_VMV: begin
                down_d      = 1'b1;
                whole_group = 1'b1;  // shifts everything out
                ins_lo_d    = 1'b1;
            end
        endcase

        sh_full = {{EB_W{1'b0}}, k_elems} * eb_d;
        if (whole_group || sh_full >= SH_W'(gb_d)) begin
            sh_d = gb_d;  // clipped to the group
        end else begin
            sh_d = sh_full[GB_W-1:0];
        end
    end

    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (in_ready) begin
            dec_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            slide_down  <= down_d;
            shift_bytes <= sh_d;
            keep_prefix <= keep_d;
            insert_low  <= ins_lo_d;
            insert_high <= ins_hi_d;
            elem_bytes  <= eb_d;
            group_bytes <= gb_d;
            dec_vs2     <= vs2;
            dec_scalar  <= scalar;
        end
    end

endmodule

// ==== source/vsldu_slide_stage.sv ====
// Vector slide datapath stage
`timescale 1ns/100ps

module vsldu_slide_stage #(
    parameter int VLEN = 128
) (
    input  logic                                           clk,
    input  logic                                           rst_n,
    input  logic                                           dec_valid,
    output logic                                           dec_ready,
    input  logic                                           slide_down,
    input  logic [$clog2(vsldu_pkg::MAX_LMUL*VLEN/8+1)-1:0] shift_bytes,
    input  logic                                           keep_prefix,
    input  logic                                           insert_low,
    input  logic                                           insert_high,
    input  logic [vsldu_pkg::EB_W-1:0]                     elem_bytes,
    input  logic [$clog2(vsldu_pkg::MAX_LMUL*VLEN/8+1)-1:0] group_bytes,
    input  logic [vsldu_pkg::MAX_LMUL*VLEN-1:0]            dec_vs2,
    input  logic [vsldu_pkg::ELEN-1:0]                     dec_scalar,
    output logic                                           out_valid,
    input  logic                                           out_ready,
    output logic [vsldu_pkg::MAX_LMUL*VLEN-1:0]            result
);
    import vsldu_pkg::*;

    localparam int DW   = MAX_LMUL * VLEN;
    localparam int NB   = DW / 8;
    localparam int GB_W = $clog2(NB + 1);

    logic [DW-1:0]   src_g;
    logic [DW-1:0]   moved;
    logic [DW-1:0]   next_result;
    logic [GB_W-1:0] ins_base;

    // source restricted to the active group
    always_comb begin
        for (int i = 0; i < NB; i++) begin
            if (GB_W'(i) < group_bytes) begin
                src_g[8*i +: 8] = dec_vs2[8*i +: 8];
            end else begin
                src_g[8*i +: 8] = 8'h00;
            end
        end
    end

    // log-depth byte barrel shifter, one stage per shift bit
    always_comb begin
        moved = src_g;
        for (int b = 0; b < GB_W; b++) begin
            if (shift_bytes[b]) begin
                if (slide_down) begin
                    moved = moved >> (8 << b);
                end else begin
                    moved = moved << (8 << b);
                end
            end
        end
    end

    // start byte of the scalar slot
    assign ins_base = insert_high ? (group_bytes - GB_W'(elem_bytes)) : '0;

    // prefix fill, scalar insert and group clear
    always_comb begin
        int off;
        for (int i = 0; i < NB; i++) begin
            off = i - int'(ins_base);
            next_result[8*i +: 8] = moved[8*i +: 8];
            if (!slide_down && keep_prefix && GB_W'(i) < shift_bytes) begin
                next_result[8*i +: 8] = src_g[8*i +: 8];  // vacated bytes keep source
            end
            if ((insert_low || insert_high) && off >= 0 && off < int'(elem_bytes)) begin
                next_result[8*i +: 8] = dec_scalar[8*off +: 8];
            end
            if (GB_W'(i) >= group_bytes) begin
                next_result[8*i +: 8] = 8'h00;  // above the group
            end
        end
    end

    assign dec_ready = !out_valid || out_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (dec_ready) begin
            out_valid <= dec_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (dec_valid && dec_ready) begin
            result <= next_result;  // held while stalled
        end
    end

endmodule

// ==== source/vsldu_top.sv ====
// Vector slide unit top
`timescale 1ns/100ps

module vsldu_top #(
    parameter int VLEN = 128
) (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                in_valid,
    output logic                                in_ready,
    input  vsldu_pkg::sldu_op_e                 op,
    input  vsldu_pkg::sew_e                     sew,
    input  vsldu_pkg::lmul_e                    lmul,
    input  logic [vsldu_pkg::MAX_LMUL*VLEN-1:0] vs2,
    input  logic [vsldu_pkg::ELEN-1:0]          scalar,
    output logic                                out_valid,
    input  logic                                out_ready,
    output logic [vsldu_pkg::MAX_LMUL*VLEN-1:0] result
);
    import vsldu_pkg::*;

    localparam int DW   = MAX_LMUL * VLEN;
    localparam int GB_W = $clog2(DW / 8 + 1);

    logic            dec_valid;
    logic            dec_ready;
    logic            slide_down;
    logic [GB_W-1:0] shift_bytes;
    logic            keep_prefix;
    logic            insert_low;
    logic            insert_high;
    logic [EB_W-1:0] elem_bytes;
    logic [GB_W-1:0] group_bytes;
    logic [DW-1:0]   dec_vs2;
    logic [ELEN-1:0] dec_scalar;

    vsldu_decode #(.VLEN(VLEN)) u_decode (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .sew(sew), .lmul(lmul), .vs2(vs2), .scalar(scalar),
        .dec_valid(dec_valid), .dec_ready(dec_ready),
        .slide_down(slide_down), .shift_bytes(shift_bytes),
        .keep_prefix(keep_prefix), .insert_low(insert_low),
        .insert_high(insert_high), .elem_bytes(elem_bytes),
        .group_bytes(group_bytes), .dec_vs2(dec_vs2), .dec_scalar(dec_scalar)
    );

    vsldu_slide_stage #(.VLEN(VLEN)) u_slide (
        .clk(clk), .rst_n(rst_n),
        .dec_valid(dec_valid), .dec_ready(dec_ready),
        .slide_down(slide_down), .shift_bytes(shift_bytes),
        .keep_prefix(keep_prefix), .insert_low(insert_low),
        .insert_high(insert_high), .elem_bytes(elem_bytes),
        .group_bytes(group_bytes), .dec_vs2(dec_vs2), .dec_scalar(dec_scalar),
        .out_valid(out_valid), .out_ready(out_ready), .result(result)
    );

endmodule

// ==== verif/vsldu_assert.sv ====
// Slide unit handshake assertions
`timescale 1ns/100ps

module vsldu_assert #(
    parameter int VLEN = 128
) (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                in_valid,
    input logic                                in_ready,
    input logic                                out_valid,
    input logic                                out_ready,
    input logic [vsldu_pkg::MAX_LMUL*VLEN-1:0] result
);

    int fail_count = 0;  // failed assertions so far

    // output frozen while the sink stalls
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(result))
        else begin
            fail_count++;
            $error("output valid or result changed while stalled");
        end

    a_reset_idle: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else begin
            fail_count++;
            $error("out_valid high during reset");
        end

    // two stages, so two cycles with a ready sink
    a_latency: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && in_ready && out_ready ##1 out_ready |=> out_valid)
        else begin
            fail_count++;
            $error("no result two cycles after an accepted input");
        end

endmodule

bind vsldu_top vsldu_assert #(.VLEN(VLEN)) u_vsldu_assert (
    .clk(clk), .rst_n(rst_n),
    .in_valid(in_valid), .in_ready(in_ready),
    .out_valid(out_valid), .out_ready(out_ready), .result(result)
);

// ==== verif/tb_vsldu.sv ====
// Slide unit testbench
`timescale 1ns/100ps

module tb_vsldu;
    import vsldu_pkg::*;

    localparam int VLEN     = 128;
    localparam int DW       = MAX_LMUL * VLEN;
    localparam int REPS     = 8;
    localparam int N_SWEEP  = 5 * 3 * 3 * REPS;
    localparam int N_EDGE   = 2 * 3 * 3 * 3;
    localparam int N_STREAM = 40;
    localparam int N_STALL  = 200;
    localparam int LIMIT    = 4 * (N_SWEEP + N_EDGE + N_STREAM + N_STALL) + 200;

    logic            clk;
    logic            rst_n;
    logic            in_valid;
    logic            in_ready;
    sldu_op_e        op;
    sew_e            sew;
    lmul_e           lmul;
    logic [DW-1:0]   vs2;
    logic [ELEN-1:0] scalar;
    logic            out_valid;
    logic            out_ready;
    logic [DW-1:0]   result;

    integer        seed;
    integer        rdy_seed;  // separate stream for the sink
    int            errors;
    int            checked;
    int            cycles;
    logic          check_latency;
    logic          random_ready;
    logic          was_stalled;
    logic [DW-1:0] held_result;

    logic [DW-1:0] exp_q[$];  // expected results in order
    sldu_op_e      op_q[$];
    int            cyc_q[$];  // accept cycle of each input

    vsldu_top #(.VLEN(VLEN)) u_vsldu_top (
        .clk(clk), .rst_n(rst_n),
        .in_valid(in_valid), .in_ready(in_ready),
        .op(op), .sew(sew), .lmul(lmul), .vs2(vs2), .scalar(scalar),
        .out_valid(out_valid), .out_ready(out_ready), .result(result)
    );

    always #5 clk = ~clk;

    function automatic int elem_width(sew_e s);
        case (s)
            SEW_16:  return 16;
            SEW_32:  return 32;
            default: return 8;
        endcase
    endfunction

    function automatic int group_width(lmul_e l);
        case (l)
            LMUL_2:  return 2 * VLEN;
            LMUL_4:  return 4 * VLEN;
            default: return VLEN;
        endcase
    endfunction

    // expected result, built element by element
    function automatic logic [DW-1:0] slide_ref(sldu_op_e o, sew_e s, lmul_e l,
                                                logic [DW-1:0] src, logic [ELEN-1:0] x);
        int              e;
        int              n;
        longint          k;
        longint          j;
        logic            take_src;
        logic [ELEN-1:0] elem;
        logic [DW-1:0]   res;
        e   = elem_width(s);
        n   = group_width(l) / e;
        k   = longint'(x);  // full unsigned offset
        res = '0;  // bits above the group stay zero
        for (int i = 0; i < n; i++) begin
            take_src = 1'b0;
            j        = 0;
            elem     = '0;
            case (o)
                SLDU_SLIDEUP: begin
                    take_src = 1'b1;
                    j        = (i < k) ? i : i - k;
                end
                SLDU_SLIDEDOWN: begin
                    if (i + k < n) begin
                        take_src = 1'b1;
                        j        = i + k;
                    end
                end
                SLDU_SLIDE1UP: begin
                    if (i == 0) begin
                        elem = x;
                    end else begin
                        take_src = 1'b1;
                        j        = i - 1;
                    end
                end
                SLDU_SLIDE1DOWN: begin
                    if (i < n - 1) begin
                        take_src = 1'b1;
                        j        = i + 1;
                    end else begin
                        elem = x;
                    end
                end
                SLDU_VMV: begin
                    if (i == 0) begin
                        elem = x;
                    end
                end
                default: ;
            endcase
            if (take_src) begin
                for (int b = 0; b < e; b++) begin
                    elem[b] = src[j * e + b];
                end
            end
            for (int b = 0; b < e; b++) begin
                res[i * e + b] = elem[b];
            end
        end
        return res;
    endfunction

    task automatic transfer(sldu_op_e o, sew_e s, lmul_e l, logic [DW-1:0] v,
                            logic [ELEN-1:0] x);
        logic accepted;
        @(negedge clk);
        in_valid = 1'b1;
        op       = o;
        sew      = s;
        lmul     = l;
        vs2      = v;
        scalar   = x;
        accepted = 1'b0;
        while (!accepted) begin
            @(posedge clk);
            accepted = in_ready;
        end
    endtask

    task automatic idle_cycles(int n);
        @(negedge clk);
        in_valid = 1'b0;
        repeat (n) @(negedge clk);
    endtask

    // whole vector random, so bits above small groups are nonzero too
    task automatic make_data(output logic [DW-1:0] v);
        for (int w = 0; w < DW / 32; w++) begin
            v[32*w +: 32] = $random(seed);
        end
    endtask

    task automatic send_random(sldu_op_e o, sew_e s, lmul_e l);
        logic [DW-1:0]   v;
        logic [ELEN-1:0] x;
        int              n;
        n = group_width(l) / elem_width(s);
        make_data(v);
        if (o == SLDU_SLIDEUP || o == SLDU_SLIDEDOWN) begin
            x = $unsigned($random(seed)) % (n + 4);  // offsets 0 to N+3
        end else begin
            x = $random(seed);
        end
        transfer(o, s, l, v, x);
    endtask

    task automatic send_any();
        sldu_op_e o;
        sew_e     s;
        lmul_e    l;
        o = sldu_op_e'($unsigned($random(seed)) % 5);
        s = sew_e'($unsigned($random(seed)) % 3);
        l = lmul_e'($unsigned($random(seed)) % 3);
        send_random(o, s, l);
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        idle_cycles(0);
        while (exp_q.size() != 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("%0d results never came out by time %0t", exp_q.size(), $time);
            errors++;
            exp_q.delete();
            op_q.delete();
            cyc_q.delete();
        end
    endtask

    always @(negedge clk) begin
        if (random_ready) begin
            out_ready = ($random(rdy_seed) & 1) != 0;  // about half the cycles stalled
        end else begin
            out_ready = 1'b1;
        end
    end

    // scoreboard, cycle count and timeout
    always @(posedge clk) begin
        logic [DW-1:0] want;
        sldu_op_e      want_op;
        int            acc_cyc;
        cycles++;
        if (cycles >= LIMIT) begin
            $display("timeout after %0d cycles with %0d results outstanding",
                     cycles, exp_q.size());
            $display("Test FAILED");
            $finish;
        end else if (rst_n) begin
            if (in_valid && in_ready) begin
                exp_q.push_back(slide_ref(op, sew, lmul, vs2, scalar));
                op_q.push_back(op);
                cyc_q.push_back(cycles);
            end
            if (check_latency && in_valid && !in_ready) begin
                $display("input stalled at %0t during steady flow", $time);
                errors++;
            end
            if (was_stalled && (out_valid !== 1'b1 || result !== held_result)) begin
                $display("output changed at %0t while the sink was stalled", $time);
                errors++;
            end
            if (out_valid && out_ready) begin
                if (exp_q.size() == 0) begin
                    $display("result at %0t arrived with nothing outstanding", $time);
                    errors++;
                end else begin
                    want    = exp_q.pop_front();
                    want_op = op_q.pop_front();
                    acc_cyc = cyc_q.pop_front();
                    checked++;
                    if (result !== want) begin
                        $display("mismatch at %0t: %s expected %h got %h",
                                 $time, want_op.name(), want, result);
                        errors++;
                    end
                    if (check_latency && cycles - acc_cyc != 2) begin
                        $display("result for %s at %0t came %0d cycles after its input",
                                 want_op.name(), $time, cycles - acc_cyc);
                        errors++;
                    end
                end
            end
            was_stalled = out_valid && !out_ready;
            held_result = result;
        end
    end

    initial begin
        logic [DW-1:0]   v;
        logic [ELEN-1:0] offs[3];
        int              n;
        seed          = 32'hcc33;
        rdy_seed      = ~32'hcc33;
        clk           = 1'b0;
        rst_n         = 1'b0;
        in_valid      = 1'b0;
        op            = SLDU_SLIDEUP;
        sew           = SEW_8;
        lmul          = LMUL_1;
        vs2           = '0;
        scalar        = '0;
        out_ready     = 1'b1;
        errors        = 0;
        checked       = 0;
        cycles        = 0;
        check_latency = 1'b0;
        random_ready  = 1'b0;
        was_stalled   = 1'b0;
        held_result   = '0;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        if (out_valid !== 1'b0 || in_ready !== 1'b1) begin
            $display("mismatch at %0t: after reset out_valid %b in_ready %b, expected 0 and 1",
                     $time, out_valid, in_ready);
            errors++;
        end

        // every op, width and group size
        for (int o = 0; o < 5; o++) begin
            for (int s = 0; s < 3; s++) begin
                for (int l = 0; l < 3; l++) begin
                    repeat (REPS) send_random(sldu_op_e'(o), sew_e'(s), lmul_e'(l));
                end
            end
        end

        // offsets at and past the element count
        for (int s = 0; s < 3; s++) begin
            for (int l = 0; l < 3; l++) begin
                n       = group_width(lmul_e'(l)) / elem_width(sew_e'(s));
                offs[0] = n;
                offs[1] = n + 5;
                offs[2] = 32'hffff_ffff;
                for (int t = 0; t < 3; t++) begin
                    make_data(v);
                    transfer(SLDU_SLIDEUP, sew_e'(s), lmul_e'(l), v, offs[t]);
                    make_data(v);
                    transfer(SLDU_SLIDEDOWN, sew_e'(s), lmul_e'(l), v, offs[t]);
                end
            end
        end
        drain();

        // back to back inputs, fixed two cycle latency
        check_latency = 1'b1;
        repeat (N_STREAM) send_any();
        drain();
        check_latency = 1'b0;

        // random gaps and random sink stalls
        random_ready = 1'b1;
        repeat (N_STALL) begin
            if ($random(seed) & 1) begin
                idle_cycles($unsigned($random(seed)) % 3);
            end
            send_any();
        end
        random_ready = 1'b0;
        drain();

        repeat (3) @(negedge clk);
        errors += u_vsldu_top.u_vsldu_assert.fail_count;  // bound assertion failures
        $display("%0d errors in %0d checked results", errors, checked);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/vsldu_pkg.sv
source/vsldu_decode.sv
source/vsldu_slide_stage.sv
source/vsldu_top.sv
verif/vsldu_assert.sv
verif/tb_vsldu.sv

// ==== Bender.yml ====
package:
  name: vsldu

sources:
  - files:
      - source/vsldu_pkg.sv
      - source/vsldu_decode.sv
      - source/vsldu_slide_stage.sv
      - source/vsldu_top.sv
  - target: test
    files:
      - verif/vsldu_assert.sv
      - verif/tb_vsldu.sv
